// ==== logic/dcache_settings.svh ====
// data cache geometry and address field widths
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// --------------------
// processor side

`define DC_ADDR_W         30 // word address, byte bits already dropped
`define DC_WORD_W         32

// --------------------
// line layout

`define DC_WORDS_PER_LINE 4
`define DC_OFFSET_W       2   // word select inside a line
`define DC_LINE_W         128 // words per line times word width

// --------------------
// set organisation

`define DC_SETS           4
`define DC_INDEX_W        2
`define DC_WAYS           2 // one fill-order bit per set is enough for two ways

// tag is what is left of the word address above index and offset
`define DC_TAG_W          26

// --------------------
// memory side

// memory moves whole lines, addressed by tag and index
`define DC_BLOCK_ADDR_W   28

`endif

// ==== logic/dcache_pkg.sv ====
// shared types of the data cache, the line seen as a whole or as words
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

	// --------------------
	// cache line

	// the same 128 bits, read two ways
	// bits  whole line, as moved to and from the slow memory
	// words per-word view, word 0 in the low bits
	typedef union packed {
		logic [`DC_LINE_W-1:0] bits;
		logic [`DC_WORDS_PER_LINE-1:0][`DC_WORD_W-1:0] words;
	} cache_line_u;

endpackage

`default_nettype wire

// ==== logic/cache_way.sv ====
// one cache way holding valid, dirty, tag and line per set, with hit check and writes
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module cache_way (
	input  wire                        clk,
	input  wire                        proc_reset,
	input  wire [`DC_ADDR_W-1:0]       proc_addr,
	input  wire [`DC_WORD_W-1:0]       proc_wdata,
	input  dcache_pkg::cache_line_u    mem_rdata,
	input  wire                        word_we,
	input  wire                        fill_we,
	output logic                       hit,
	output logic                       dirty,
	output logic [`DC_TAG_W-1:0]       tag,
	output dcache_pkg::cache_line_u    line
);

	// --------------------
	// address fields

	logic [`DC_OFFSET_W-1:0] word_off;
	logic [`DC_INDEX_W-1:0]  set_idx;
	logic [`DC_TAG_W-1:0]    req_tag;

	assign word_off = proc_addr[`DC_OFFSET_W-1:0];
	assign set_idx  = proc_addr[`DC_OFFSET_W +: `DC_INDEX_W];
	assign req_tag  = proc_addr[`DC_ADDR_W-1 -: `DC_TAG_W];

	// --------------------
	// storage

	logic [`DC_SETS-1:0]        valid_q;
	logic [`DC_SETS-1:0]        dirty_q;
	logic [`DC_TAG_W-1:0]       tag_q [`DC_SETS];
	dcache_pkg::cache_line_u    line_q [`DC_SETS];

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			// nothing resident after reset
			valid_q <= '0;
			dirty_q <= '0;
			for (int s = 0; s < `DC_SETS; s++) begin
				tag_q[s]  <= '0;
				line_q[s] <= '0;
			end
		end else if (fill_we) begin
			// refill from memory leaves the line clean
			line_q[set_idx]  <= mem_rdata;
			tag_q[set_idx]   <= req_tag;
			valid_q[set_idx] <= 1'b1;
			dirty_q[set_idx] <= 1'b0;
		end else if (word_we) begin
			line_q[set_idx].words[word_off] <= proc_wdata; // write hit
			dirty_q[set_idx]                <= 1'b1;       // now differs from memory
		end
	end

	// --------------------
	// lookup of the indexed set

	assign hit   = valid_q[set_idx] && (tag_q[set_idx] == req_tag);
	assign dirty = dirty_q[set_idx];
	assign tag   = tag_q[set_idx]; // victim tag for write-back address
	assign line  = line_q[set_idx];

	// --------------------
	// checks

	// the controller never writes a word and refills the same way at once
	a_no_word_and_fill: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(word_we && fill_we)
	);

endmodule

`default_nettype wire

// ==== logic/way_arbiter.sv ====
// way arbiter that merges way hits, picks read data, keeps fill order and offers the victim
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module way_arbiter (
	input  wire                        clk,
	input  wire                        proc_reset,
	input  wire [`DC_ADDR_W-1:0]       proc_addr,
	input  wire [`DC_WAYS-1:0]         way_hit,
	input  wire [`DC_WAYS-1:0]         way_dirty,
	input  wire [`DC_TAG_W-1:0]        way_tag [`DC_WAYS],
	input  dcache_pkg::cache_line_u    way_line [`DC_WAYS],
	input  wire [`DC_WAYS-1:0]         fill_we,
	output logic                       hit,
	output logic [`DC_WAYS-1:0]        hit_way,
	output logic [`DC_WAYS-1:0]        victim_way,
	output logic                       victim_dirty,
	output logic [`DC_TAG_W-1:0]       victim_tag,
	output logic [`DC_WORD_W-1:0]      proc_rdata,
	output logic [`DC_LINE_W-1:0]      mem_wdata
);

	logic [`DC_OFFSET_W-1:0] word_off;
	logic [`DC_INDEX_W-1:0]  set_idx;

	assign word_off = proc_addr[`DC_OFFSET_W-1:0];
	assign set_idx  = proc_addr[`DC_OFFSET_W +: `DC_INDEX_W];

	// --------------------
	// hit merge and read data

	assign hit     = |way_hit;
	assign hit_way = way_hit;

	always_comb begin
		proc_rdata = '0; // zero on a miss
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (way_hit[w]) begin
				proc_rdata = way_line[w].words[word_off];
			end
		end
	end

	// --------------------
	// fill order

	logic [`DC_SETS-1:0] mru_q; // way filled last in each set
	logic                victim_idx;

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			mru_q <= '0;
		end else if (|fill_we) begin
			mru_q[set_idx] <= fill_we[1]; // only flips on a fill
		end
	end

	// victim is the way not filled last
	assign victim_idx   = ~mru_q[set_idx];
	assign victim_way   = {{(`DC_WAYS-1){1'b0}}, 1'b1} << victim_idx;
	assign victim_dirty = way_dirty[victim_idx];
	assign victim_tag   = way_tag[victim_idx];
	assign mem_wdata    = way_line[victim_idx].bits; // write-back payload

	// --------------------
	// checks

	// tags are unique inside a set, so two ways never match together
	a_onehot_hit: assert property (
		@(posedge clk) disable iff (proc_reset)
		$onehot0(way_hit)
	);

endmodule

`default_nettype wire

// ==== logic/miss_controller.sv ====
// miss controller FSM: compare, write-back of a dirty victim, allocate from memory
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module miss_controller (
	input  wire                          clk,
	input  wire                          proc_reset,
	input  wire                          proc_read,
	input  wire                          proc_write,
	input  wire [`DC_ADDR_W-1:0]         proc_addr,
	input  wire                          hit,
	input  wire [`DC_WAYS-1:0]           hit_way,
	input  wire [`DC_WAYS-1:0]           victim_way,
	input  wire                          victim_dirty,
	input  wire [`DC_TAG_W-1:0]          victim_tag,
	input  wire                          mem_ready,
	output logic [`DC_WAYS-1:0]          word_we,
	output logic [`DC_WAYS-1:0]          fill_we,
	output logic                         proc_stall,
	output logic                         mem_read,
	output logic                         mem_write,
	output logic [`DC_BLOCK_ADDR_W-1:0]  mem_addr
);

	// --------------------
	// state encoding

	localparam logic [1:0] ST_COMPARE    = 2'b00;
	localparam logic [1:0] ST_WRITE_BACK = 2'b01;
	localparam logic [1:0] ST_ALLOCATE   = 2'b10;
	localparam logic [1:0] ST_IDLE       = 2'b11;

	logic [1:0] state_q;
	logic [1:0] state_d;

	logic                       req;
	logic                       miss;
	logic [`DC_INDEX_W-1:0]     set_idx;
	logic [`DC_BLOCK_ADDR_W-1:0] req_block;

	assign req       = proc_read | proc_write;
	assign miss      = req & ~hit;
	assign set_idx   = proc_addr[`DC_OFFSET_W +: `DC_INDEX_W];
	assign req_block = proc_addr[`DC_ADDR_W-1:`DC_OFFSET_W]; // tag then index

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= ST_IDLE; // one quiet cycle before compare
		end else begin
			state_q <= state_d;
		end
	end

	// --------------------
	// next state and outputs

	always_comb begin
		state_d    = state_q;
		word_we    = '0;
		fill_we    = '0;
		proc_stall = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = req_block;

		case (state_q)
			ST_IDLE: begin
				state_d = ST_COMPARE;
			end

			ST_COMPARE: begin
				proc_stall = miss; // a hit finishes this cycle
				if (proc_write && hit) begin
					word_we = hit_way;
				end
				if (miss) begin
					// dirty victim goes out first
					state_d = victim_dirty ? ST_WRITE_BACK : ST_ALLOCATE;
				end
			end

			ST_WRITE_BACK: begin
				proc_stall = 1'b1;
				mem_write  = 1'b1;
				mem_addr   = {victim_tag, set_idx}; // victim block, same set
				if (mem_ready) begin
					state_d = ST_ALLOCATE;
				end
			end

			ST_ALLOCATE: begin
				proc_stall = 1'b1;
				mem_read   = 1'b1;
				if (mem_ready) begin
					fill_we = victim_way; // line lands at this edge
					state_d = ST_COMPARE;
				end
			end

			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// --------------------
	// memory side checks

	a_no_read_and_write: assert property (
		@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write)
	);

	// a waiting request keeps its kind and its address
	a_mem_req_held: assert property (
		@(posedge clk) disable iff (proc_reset)
		((mem_read || mem_write) && !mem_ready) |=>
			($stable(mem_addr) && $stable(mem_read) && $stable(mem_write))
	);

endmodule

`default_nettype wire

// ==== logic/dcache_top.sv ====
// data cache top level, two-way write-back cache between processor and slow memory
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
	input  wire                          clk,
	input  wire                          proc_reset,
	// processor side
	input  wire                          proc_read,
	input  wire                          proc_write,
	input  wire [`DC_ADDR_W-1:0]         proc_addr,
	input  wire [`DC_WORD_W-1:0]         proc_wdata,
	output logic [`DC_WORD_W-1:0]        proc_rdata,
	output logic                         proc_stall,
	// memory side
	output logic                         mem_read,
	output logic                         mem_write,
	output logic [`DC_BLOCK_ADDR_W-1:0]  mem_addr,
	output logic [`DC_LINE_W-1:0]        mem_wdata,
	input  wire [`DC_LINE_W-1:0]         mem_rdata,
	input  wire                          mem_ready
);

	// --------------------
	// internal wires

	logic [`DC_WAYS-1:0]        way_hit;
	logic [`DC_WAYS-1:0]        way_dirty;
	logic [`DC_TAG_W-1:0]       way_tag [`DC_WAYS];
	dcache_pkg::cache_line_u    way_line [`DC_WAYS];

	logic [`DC_WAYS-1:0]        word_we;
	logic [`DC_WAYS-1:0]        fill_we;
	logic                       hit;
	logic [`DC_WAYS-1:0]        hit_way;
	logic [`DC_WAYS-1:0]        victim_way;
	logic                       victim_dirty;
	logic [`DC_TAG_W-1:0]       victim_tag;

	miss_controller u_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.mem_ready    (mem_ready),
		.word_we      (word_we),
		.fill_we      (fill_we),
		.proc_stall   (proc_stall),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr)
	);

	// --------------------
	// way stores

	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
		cache_way u_way (
			.clk        (clk),
			.proc_reset (proc_reset),
			.proc_addr  (proc_addr),
			.proc_wdata (proc_wdata),
			.mem_rdata  (mem_rdata),
			.word_we    (word_we[w]),
			.fill_we    (fill_we[w]),
			.hit        (way_hit[w]),
			.dirty      (way_dirty[w]),
			.tag        (way_tag[w]),
			.line       (way_line[w])
		);
	end

	way_arbiter u_arb (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_addr    (proc_addr),
		.way_hit      (way_hit),
		.way_dirty    (way_dirty),
		.way_tag      (way_tag),
		.way_line     (way_line),
		.fill_we      (fill_we),
		.hit          (hit),
		.hit_way      (hit_way),
		.victim_way   (victim_way),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.proc_rdata   (proc_rdata),
		.mem_wdata    (mem_wdata)
	);

endmodule

`default_nettype wire

// ==== test/slow_memory.sv ====
// behavioral slow memory, whole-line transfers after a random wait of 1 to 6 cycles
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module slow_memory (
	input  wire                          clk,
	input  wire                          mem_read,
	input  wire                          mem_write,
	input  wire [`DC_BLOCK_ADDR_W-1:0]   mem_addr,
	input  wire [`DC_LINE_W-1:0]         mem_wdata,
	output logic [`DC_LINE_W-1:0]        mem_rdata,
	output logic                         mem_ready
);

	localparam int BLOCKS    = 64; // 16 tags times 4 sets
	localparam int MIN_DELAY = 1;
	localparam int MAX_DELAY = 6;

	logic [`DC_LINE_W-1:0] store [BLOCKS];
	logic                  busy;
	logic [2:0]            wait_left;
	logic                  ready_next;
	logic [`DC_LINE_W-1:0] rdata_next;
	logic [5:0]            blk;

	// start value of a word, from its 8-bit word address
	function automatic logic [`DC_WORD_W-1:0] start_word(input logic [7:0] wa);
		start_word = {8'hd5, wa, ~wa, wa ^ 8'h69};
	endfunction

	function automatic logic [`DC_LINE_W-1:0] start_line(input logic [5:0] b);
		start_line = {start_word({b, 2'd3}), start_word({b, 2'd2}),
			start_word({b, 2'd1}), start_word({b, 2'd0})};
	endfunction

	initial begin
		mem_ready  = 1'b0;
		mem_rdata  = '0;
		busy       = 1'b0;
		wait_left  = 3'd0;
		ready_next = 1'b0;
		rdata_next = '0;
		for (int b = 0; b < BLOCKS; b++) begin
			store[b[5:0]] = start_line(b[5:0]);
		end
	end

	// --------------------
	// request tracking, sampled mid-cycle

	always @(negedge clk) begin
		blk = mem_addr[5:0];
		if ((mem_read || mem_write) && mem_ready) begin
			if (mem_write) begin
				store[blk] = mem_wdata; // write-back lands here
			end
			busy       = 1'b0;
			ready_next = 1'b0;
		end else if (mem_read || mem_write) begin
			if (!busy) begin
				busy      = 1'b1;
				wait_left = 3'($urandom_range(MAX_DELAY, MIN_DELAY));
			end
			wait_left = wait_left - 3'd1;
			if (wait_left == 3'd0) begin
				ready_next = 1'b1;
				rdata_next = store[blk];
			end
		end
	end

	// outputs change just after the rising edge
	always @(posedge clk) begin
		#1;
		mem_ready = ready_next;
		mem_rdata = rdata_next;
	end

endmodule

`default_nettype wire

// ==== test/tb_dcache.sv ====
// testbench for the data cache, random traffic checked against a shadow memory and tag tracker
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache;

	localparam int NUM_REQ        = 2000;
	localparam int CYCLES_PER_REQ = 20; // a dirty miss needs at most 16

	logic                         clk;
	logic                         proc_reset;
	logic                         proc_read;
	logic                         proc_write;
	logic [`DC_ADDR_W-1:0]        proc_addr;
	logic [`DC_WORD_W-1:0]        proc_wdata;
	logic [`DC_WORD_W-1:0]        proc_rdata;
	logic                         proc_stall;
	logic                         mem_read;
	logic                         mem_write;
	logic [`DC_BLOCK_ADDR_W-1:0]  mem_addr;
	logic [`DC_LINE_W-1:0]        mem_wdata;
	logic [`DC_LINE_W-1:0]        mem_rdata;
	logic                         mem_ready;

	// shadow of all 256 words, plus what the cache should hold
	logic [`DC_WORD_W-1:0] shadow [256];
	logic                  tr_valid [`DC_SETS][`DC_WAYS];
	logic                  tr_dirty [`DC_SETS][`DC_WAYS];
	logic [3:0]            tr_tag [`DC_SETS][`DC_WAYS];
	logic                  tr_mru [`DC_SETS]; // way filled last

	dcache_top dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	slow_memory mem (
		.clk       (clk),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// --------------------
	// failure reporting

	task automatic end_in_failure();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic value_error(input string name, input logic [`DC_LINE_W-1:0] got,
			input logic [`DC_LINE_W-1:0] expected);
		$display("** Error: %s = %0h, expected %0h", name, got, expected);
		end_in_failure();
	endtask

	task automatic other_error(input string what);
		$display("** Error: %s", what);
		end_in_failure();
	endtask

	// initial memory contents, word address in, word out
	function automatic logic [`DC_WORD_W-1:0] initial_word(input logic [7:0] wa);
		initial_word = {8'hd5, wa, ~wa, wa ^ 8'h69};
	endfunction

	function automatic logic [`DC_LINE_W-1:0] shadow_line(input logic [5:0] blk);
		shadow_line = {shadow[{blk, 2'd3}], shadow[{blk, 2'd2}],
			shadow[{blk, 2'd1}], shadow[{blk, 2'd0}]};
	endfunction

	// --------------------
	// one processor request, from drive to completion

	task automatic run_request(input logic is_write, input logic [3:0] tag,
			input logic [1:0] idx, input logic [1:0] off, input logic [`DC_WORD_W-1:0] wdata);
		logic [7:0]                  wa;
		logic                        resident;
		logic                        way;
		logic                        victim;
		logic                        expect_wb;
		logic                        wb_done;
		logic                        fill_done;
		logic                        done;
		logic [5:0]                  wb_block;
		logic [`DC_BLOCK_ADDR_W-1:0] wb_addr;
		logic [`DC_BLOCK_ADDR_W-1:0] req_addr;

		wa       = {tag, idx, off};
		resident = 1'b0;
		way      = 1'b0;
		if (tr_valid[idx][0] && tr_tag[idx][0] == tag) begin
			resident = 1'b1;
		end
		if (tr_valid[idx][1] && tr_tag[idx][1] == tag) begin
			resident = 1'b1;
			way      = 1'b1;
		end
		victim    = ~tr_mru[idx];
		expect_wb = !resident && tr_valid[idx][victim] && tr_dirty[idx][victim];
		wb_block  = {tr_tag[idx][victim], idx};
		wb_addr   = {{(`DC_BLOCK_ADDR_W-6){1'b0}}, wb_block};
		req_addr  = {{(`DC_BLOCK_ADDR_W-6){1'b0}}, tag, idx};
		wb_done   = 1'b0;
		fill_done = 1'b0;
		done      = 1'b0;

		@(posedge clk);
		#1;
		proc_read  = !is_write;
		proc_write = is_write;
		proc_addr  = {{(`DC_ADDR_W-8){1'b0}}, wa};
		proc_wdata = wdata;

		while (!done) begin
			@(negedge clk);
			if (!proc_stall) begin
				done = 1'b1;
			end else begin
				assert (!resident) else other_error("stall on a block the tracker holds");
				assert (!fill_done) else other_error("still stalled after the refill");
				assert (!(mem_read && mem_write)) else other_error("memory read and write at once");
				if (mem_write) begin
					assert (expect_wb && !wb_done) else other_error("unexpected write-back");
					assert (mem_addr == wb_addr)
						else value_error("mem_addr", 128'(mem_addr), 128'(wb_addr));
					assert (mem_wdata == shadow_line(wb_block))
						else value_error("mem_wdata", mem_wdata, shadow_line(wb_block));
					wb_done = mem_ready;
				end
				if (mem_read) begin
					assert (!expect_wb || wb_done) else other_error("refill before the write-back");
					assert (mem_addr == req_addr)
						else value_error("mem_addr", 128'(mem_addr), 128'(req_addr));
					if (mem_ready) begin
						// line lands in the victim way at this edge
						fill_done              = 1'b1;
						tr_valid[idx][victim]  = 1'b1;
						tr_dirty[idx][victim]  = 1'b0;
						tr_tag[idx][victim]    = tag;
						tr_mru[idx]            = victim;
						way                    = victim;
					end
				end
			end
		end

		assert (!(mem_read || mem_write)) else other_error("memory request as the request completes");
		assert (resident || fill_done) else other_error("miss completed without a refill");
		if (is_write) begin
			shadow[wa]         = wdata;
			tr_dirty[idx][way] = 1'b1;
		end else begin
			assert (proc_rdata == shadow[wa])
				else value_error("proc_rdata", 128'(proc_rdata), 128'(shadow[wa]));
		end
	endtask

	// --------------------
	// main sequence

	initial begin
		logic [31:0] r;

		void'($urandom(32'h5f66));
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		for (int a = 0; a < 256; a++) begin
			shadow[a[7:0]] = initial_word(a[7:0]);
		end
		for (int s = 0; s < `DC_SETS; s++) begin
			tr_mru[s[1:0]] = 1'b0;
			for (int w = 0; w < `DC_WAYS; w++) begin
				tr_valid[s[1:0]][w[0]] = 1'b0;
				tr_dirty[s[1:0]][w[0]] = 1'b0;
				tr_tag[s[1:0]][w[0]]   = 4'd0;
			end
		end

		repeat (3) @(posedge clk);
		#1;
		proc_reset = 1'b0;
		@(negedge clk); // the idle cycle
		assert (!proc_stall && !mem_read && !mem_write)
			else other_error("stall or memory request in the cycle after reset");

		for (int n = 0; n < NUM_REQ; n++) begin
			r = $urandom;
			run_request(r[31], r[3:0], r[5:4], r[7:6], $urandom);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

	// watchdog, sized from the request count
	initial begin
		repeat (NUM_REQ * CYCLES_PER_REQ + 10) @(posedge clk);
		$display("** Error: watchdog expired before all requests completed");
		end_in_failure();
	end

endmodule

`default_nettype wire

// ==== dcache_top.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/cache_way.sv
logic/way_arbiter.sv
logic/miss_controller.sv
logic/dcache_top.sv
test/slow_memory.sv
test/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the data cache testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
	-f dcache_top.f --top-module tb_dcache -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_dcache 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi

echo "pass line not found in simulation output"
exit 1
